// ==== Makefile ====
# Verilator build for the memory stage subsystem

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "all tests passed" $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;
	import mem_stage_pkg::*;

	localparam int RAM_LATENCY = 3;
	localparam int RAM_WORDS   = 256;
	localparam int MEM_BYTES   = RAM_WORDS * 4;

	logic                 iCLOCK;
	logic                 inRESET;
	logic                 flush;
	logic                 in_valid;
	logic [DATA_W-1:0]    in_data;
	logic [REG_IDX_W-1:0] in_dest;
	logic                 in_dest_sysreg;
	logic                 in_writeback;
	logic                 in_mem_valid;
	logic [DATA_W-1:0]    in_mem_addr;
	logic [DATA_W-1:0]    in_mem_wdata;
	mem_rw_t              in_mem_rw;
	mem_order_t           in_mem_order;
	logic                 stall;
	logic [REG_IDX_W-1:0] rd_addr;
	logic                 rd_sysreg;
	logic [DATA_W-1:0]    rd_data;
	logic                 next_valid;
	logic [DATA_W-1:0]    next_data;
	logic [REG_IDX_W-1:0] next_dest;
	logic                 next_dest_sysreg;
	logic                 next_writeback;

	integer seed;
	int     cycle;
	int     work;
	int     issued;
	int     retired;
	int     last_retire;
	int     accept_cycle;

	logic [DATA_W-1:0]    shadow_gpr [32];
	logic [DATA_W-1:0]    shadow_sys [32];
	logic [7:0]           shadow_mem [MEM_BYTES];
	logic [DATA_W-1:0]    exp_data_q [$];
	logic [REG_IDX_W-1:0] exp_dest_q [$];
	logic                 exp_sys_q [$];
	logic                 exp_wb_q [$];

	mem_subsystem_top #(
		.RAM_LATENCY(RAM_LATENCY),
		.RAM_WORDS  (RAM_WORDS)
	) mem_subsystem_top_i (.*);

	always #50 iCLOCK = ~iCLOCK;

	// ----------------------------------------------------------
	// Failure reporting and shadow memory access
	// ----------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		abort_run($sformatf("FAIL %0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	function automatic int lane_count(input mem_order_t order);
		case (order)
			BYTE:    return 1;
			HALF:    return 2;
			default: return 4;
		endcase
	endfunction

	// Lanes are little endian so the lowest address lands in bits 7:0
	function automatic logic [31:0] read_lanes(input logic [31:0] addr,
		input mem_order_t order);
		logic [31:0] v;
		int          base;
		v    = '0;
		base = addr % MEM_BYTES;
		for (int i = 0; i < lane_count(order); i++)
			v[8*i +: 8] = shadow_mem[base + i];
		return v;
	endfunction

	task automatic write_lanes(input logic [31:0] addr, input mem_order_t order,
		input logic [31:0] wdata);
		int base;
		base = addr % MEM_BYTES;
		for (int i = 0; i < lane_count(order); i++)
			shadow_mem[base + i] = wdata[8*i +: 8];
	endtask

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------

	// A killed instruction is flushed later, so it never reaches writeback
	task automatic issue_instr(input logic [31:0] data, input logic [4:0] dest,
		input logic sys, input logic wb, input logic mem, input mem_rw_t rw,
		input mem_order_t order, input logic [31:0] addr, input logic [31:0] wdata,
		input logic kill);
		logic [31:0] result;
		@(negedge iCLOCK);
		in_valid       = 1'b1;
		in_data        = data;
		in_dest        = dest;
		in_dest_sysreg = sys;
		in_writeback   = wb;
		in_mem_valid   = mem;
		in_mem_rw      = rw;
		in_mem_order   = order;
		in_mem_addr    = addr;
		in_mem_wdata   = wdata;
		while (stall)
			@(negedge iCLOCK);
		accept_cycle = cycle + 1;
		work++;
		result = data;
		if (mem) begin
			if (rw == WRITE) begin
				write_lanes(addr, order, wdata);
				result = '0;
			end else begin
				result = read_lanes(addr, order);
			end
		end
		if (!kill) begin
			exp_data_q.push_back(result);
			exp_dest_q.push_back(dest);
			exp_sys_q.push_back(sys);
			exp_wb_q.push_back(wb);
			issued++;
			if (wb && sys)
				shadow_sys[dest] = result;
			else if (wb)
				shadow_gpr[dest] = result;
		end
	endtask

	task automatic plain_op(input logic [4:0] dest, input logic sys, input logic wb);
		issue_instr($random(seed), dest, sys, wb, 1'b0, READ, WORD, '0, '0, 1'b0);
	endtask

	task automatic store_op(input mem_order_t order, input logic [31:0] addr);
		issue_instr($random(seed), 5'd0, 1'b0, 1'b0, 1'b1, WRITE, order, addr,
			$random(seed), 1'b0);
	endtask

	task automatic load_op(input mem_order_t order, input logic [31:0] addr,
		input logic [4:0] dest, input logic kill);
		issue_instr($random(seed), dest, 1'b0, 1'b1, 1'b1, READ, order, addr, '0, kill);
	endtask

	task automatic go_idle();
		@(negedge iCLOCK);
		in_valid     = 1'b0;
		in_mem_valid = 1'b0;
	endtask

	task automatic wait_retired();
		while (retired < issued)
			@(posedge iCLOCK);
	endtask

	task automatic check_reg(input logic sys, input logic [4:0] idx);
		logic [31:0] exp;
		@(negedge iCLOCK);
		rd_sysreg = sys;
		rd_addr   = idx;
		#10;
		exp = sys ? shadow_sys[idx] : shadow_gpr[idx];
		assert (rd_data === exp)
			else report_mismatch($sformatf("rd_data[%s%0d]", sys ? "sys" : "gpr", idx),
				exp, rd_data);
	endtask

	// ----------------------------------------------------------
	// Retirement monitor and watchdog
	// ----------------------------------------------------------
	always @(posedge iCLOCK) begin
		cycle = cycle + 1;
		if (inRESET && next_valid) begin
			if (exp_data_q.size() == 0) begin
				abort_run("Retirement seen with no instruction outstanding");
			end else begin
				assert (next_dest === exp_dest_q[0])
					else report_mismatch("next_dest", 32'(exp_dest_q[0]), 32'(next_dest));
				assert (next_dest_sysreg === exp_sys_q[0])
					else report_mismatch("next_dest_sysreg", 32'(exp_sys_q[0]),
						32'(next_dest_sysreg));
				assert (next_writeback === exp_wb_q[0])
					else report_mismatch("next_writeback", 32'(exp_wb_q[0]),
						32'(next_writeback));
				assert (next_data === exp_data_q[0])
					else report_mismatch("next_data", exp_data_q[0], next_data);
				void'(exp_data_q.pop_front());
				void'(exp_dest_q.pop_front());
				void'(exp_sys_q.pop_front());
				void'(exp_wb_q.pop_front());
				retired++;
				last_retire = cycle;
			end
		end
	end

	initial begin
		forever begin
			@(posedge iCLOCK);
			if (cycle > work * (RAM_LATENCY + 6) + 200)
				abort_run("Timeout, the pipeline stopped making progress");
		end
	end

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------
	initial begin
		seed = 88;
		cycle = 0;
		work = 0;
		issued = 0;
		retired = 0;
		last_retire = 0;
		accept_cycle = 0;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		flush = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		in_dest = '0;
		in_dest_sysreg = 1'b0;
		in_writeback = 1'b0;
		in_mem_valid = 1'b0;
		in_mem_addr = '0;
		in_mem_wdata = '0;
		in_mem_rw = READ;
		in_mem_order = WORD;
		rd_addr = '0;
		rd_sysreg = 1'b0;
		for (int i = 0; i < 32; i++) begin
			shadow_gpr[i] = '0;
			shadow_sys[i] = '0;
		end
		for (int i = 0; i < MEM_BYTES; i++)
			shadow_mem[i] = '0;
		repeat (3) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;

		// Plain results with and without writeback
		for (int i = 1; i <= 6; i++)
			plain_op(5'(i), 1'b0, 1'b1);
		plain_op(5'd3, 1'b0, 1'b0);
		go_idle();
		wait_retired();
		for (int i = 1; i <= 6; i++)
			check_reg(1'b0, 5'(i));

		// System registers leave the general file alone
		plain_op(5'd4, 1'b1, 1'b1);
		plain_op(5'd9, 1'b1, 1'b1);
		go_idle();
		wait_retired();
		check_reg(1'b1, 5'd4);
		check_reg(1'b0, 5'd4);
		check_reg(1'b1, 5'd9);
		check_reg(1'b0, 5'd9);

		// Word store then load with the load latency measured on a quiet pipeline
		store_op(WORD, 32'h40);
		go_idle();
		wait_retired();
		load_op(WORD, 32'h40, 5'd10, 1'b0);
		go_idle();
		wait_retired();
		assert (last_retire - accept_cycle == RAM_LATENCY + 3)
			else report_mismatch("next_valid latency", RAM_LATENCY + 3,
				last_retire - accept_cycle);
		check_reg(1'b0, 5'd10);

		// Byte and halfword lanes merging in one word
		for (int b = 0; b < 4; b++)
			store_op(BYTE, 32'h80 + b);
		store_op(HALF, 32'h82);
		load_op(WORD, 32'h80, 5'd11, 1'b0);
		load_op(HALF, 32'h80, 5'd12, 1'b0);
		load_op(HALF, 32'h82, 5'd13, 1'b0);
		for (int b = 1; b < 4; b++)
			load_op(BYTE, 32'h80 + b, 5'(13 + b), 1'b0);
		for (int i = 0; i < 4; i++)
			store_op(WORD, ($random(seed) & (MEM_BYTES - 1)) & ~32'h3);
		go_idle();
		wait_retired();
		for (int i = 11; i <= 16; i++)
			check_reg(1'b0, 5'(i));

		// Under back-pressure a plain result must land after the load to r20
		load_op(WORD, 32'h40, 5'd20, 1'b0);
		plain_op(5'd20, 1'b0, 1'b1);
		go_idle();
		assert (stall === 1'b1)
			else report_mismatch("stall", 32'd1, 32'(stall));
		load_op(HALF, 32'h82, 5'd24, 1'b0);
		plain_op(5'd25, 1'b0, 1'b1);
		plain_op(5'd24, 1'b1, 1'b1);
		go_idle();
		wait_retired();
		check_reg(1'b0, 5'd20);
		check_reg(1'b0, 5'd24);
		check_reg(1'b0, 5'd25);
		check_reg(1'b1, 5'd24);

		// Flushing a pending load must leave r21 with its plain value
		plain_op(5'd21, 1'b0, 1'b1);
		go_idle();
		wait_retired();
		load_op(WORD, 32'h80, 5'd21, 1'b1);
		go_idle();
		@(negedge iCLOCK);
		assert (stall === 1'b1)
			else report_mismatch("stall", 32'd1, 32'(stall));
		flush = 1'b1;
		@(negedge iCLOCK);
		flush = 1'b0;
		while (stall)
			@(negedge iCLOCK);
		plain_op(5'd22, 1'b0, 1'b1);
		load_op(HALF, 32'h82, 5'd23, 1'b0);
		go_idle();
		wait_retired();
		repeat (RAM_LATENCY + 4) @(posedge iCLOCK);

		for (int i = 0; i < 32; i++) begin
			check_reg(1'b0, 5'(i));
			check_reg(1'b1, 5'(i));
		end
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
	parameter int RAM_LATENCY = 3,
	parameter int RAM_WORDS   = 256
) (
	input  wire                              iCLOCK,
	input  wire                              inRESET,
	input  wire                              req,
	input  wire mem_stage_pkg::mem_order_t   req_order,
	input  wire mem_stage_pkg::mem_rw_t      req_rw,
	input  wire [mem_stage_pkg::DATA_W-1:0]  req_addr,
	input  wire [mem_stage_pkg::DATA_W-1:0]  req_wdata,
	output logic                             busy,
	output logic                             resp,
	output logic [mem_stage_pkg::DATA_W-1:0] resp_data
);
	import mem_stage_pkg::*;

	localparam int IDX_W = $clog2(RAM_WORDS);
	localparam int CNT_W = $clog2(RAM_LATENCY + 1);

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic [IDX_W-1:0]  idx;
	logic [1:0]        lane;
	logic [3:0]        lane_en;
	logic [DATA_W-1:0] wide_wdata;
	logic [DATA_W-1:0] lane_mask;
	logic [DATA_W-1:0] shifted;
	logic              pending;
	logic [CNT_W-1:0]  cnt;

	// Upper address bits wrap around the array
	assign idx  = req_addr[IDX_W+1:2];
	assign lane = req_addr[1:0];

	// ----------------------------------------------------------
	// Lane selection
	// ----------------------------------------------------------
	always_comb begin
		case (req_order)
			BYTE: begin
				lane_en    = 4'b0001 << lane;
				wide_wdata = {4{req_wdata[7:0]}};
				lane_mask  = 32'h0000_00ff;
			end
			HALF: begin
				lane_en    = 4'b0011 << lane;
				wide_wdata = {2{req_wdata[15:0]}};
				lane_mask  = 32'h0000_ffff;
			end
			default: begin
				lane_en    = 4'b1111;
				wide_wdata = req_wdata;
				lane_mask  = 32'hffff_ffff;
			end
		endcase
	end

	assign shifted = mem[idx] >> {lane, 3'b000};

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < RAM_WORDS; i++)
				mem[i] <= '0;
		end else if (req && req_rw == WRITE) begin
			for (int b = 0; b < 4; b++) begin
				if (lane_en[b])
					mem[idx][8*b +: 8] <= wide_wdata[8*b +: 8];
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (req)
			resp_data <= (req_rw == READ) ? (shifted & lane_mask) : '0;
	end

	// ----------------------------------------------------------
	// Latency counter
	// ----------------------------------------------------------
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pending <= 1'b0;
			cnt     <= '0;
		end else if (req) begin
			pending <= 1'b1;
			cnt     <= CNT_W'(RAM_LATENCY - 1);
		end else if (resp) begin
			pending <= 1'b0;
		end else if (pending) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign resp = pending && (cnt == '0);
	assign busy = req || pending;

	assert property (@(posedge iCLOCK) disable iff (!inRESET) req |-> !pending)
		else $error("FAIL %0t req expected 0 actual 1 while pending", $time);

	assert property (@(posedge iCLOCK) disable iff (!inRESET) req |-> req_order != NONE)
		else $error("FAIL %0t req_order expected !NONE actual %0d", $time, req_order);

endmodule

`default_nettype wire

// ==== design/issue_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_register (
	input  wire                                 iCLOCK,
	input  wire                                 inRESET,
	input  wire                                 flush,
	input  wire                                 lock,
	input  wire                                 in_valid,
	input  wire [mem_stage_pkg::DATA_W-1:0]     in_data,
	input  wire [mem_stage_pkg::REG_IDX_W-1:0]  in_dest,
	input  wire                                 in_dest_sysreg,
	input  wire                                 in_writeback,
	input  wire                                 in_mem_valid,
	input  wire [mem_stage_pkg::DATA_W-1:0]     in_mem_addr,
	input  wire [mem_stage_pkg::DATA_W-1:0]     in_mem_wdata,
	input  wire mem_stage_pkg::mem_rw_t         in_mem_rw,
	input  wire mem_stage_pkg::mem_order_t      in_mem_order,
	output logic                                prev_valid,
	output logic [mem_stage_pkg::DATA_W-1:0]    prev_data,
	output logic [mem_stage_pkg::REG_IDX_W-1:0] prev_dest,
	output logic                                prev_dest_sysreg,
	output logic                                prev_writeback,
	output logic                                prev_mem_valid,
	output logic [mem_stage_pkg::DATA_W-1:0]    prev_mem_addr,
	output logic [mem_stage_pkg::DATA_W-1:0]    prev_mem_wdata,
	output mem_stage_pkg::mem_rw_t              prev_mem_rw,
	output mem_stage_pkg::mem_order_t           prev_mem_order
);
	import mem_stage_pkg::*;

	// The valids are the only state that flush has to kill
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			prev_valid     <= 1'b0;
			prev_mem_valid <= 1'b0;
		end else if (flush) begin
			prev_valid     <= 1'b0;
			prev_mem_valid <= 1'b0;
		end else if (!lock) begin
			prev_valid     <= in_valid;
			prev_mem_valid <= in_mem_valid;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!lock) begin
			prev_data        <= in_data;
			prev_dest        <= in_dest;
			prev_dest_sysreg <= in_dest_sysreg;
			prev_writeback   <= in_writeback;
			prev_mem_addr    <= in_mem_addr;
			prev_mem_wdata   <= in_mem_wdata;
			prev_mem_rw      <= in_mem_rw;
			prev_mem_order   <= in_mem_order;
		end
	end

	// Execute side must never hand over a sizeless memory operation
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		prev_mem_valid |-> prev_mem_order != NONE)
		else $error("FAIL %0t prev_mem_order expected !NONE actual %0d",
			$time, prev_mem_order);

endmodule

`default_nettype wire

// ==== design/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

	// ----------------------------------------------------------
	// Widths
	// ----------------------------------------------------------
	localparam int DATA_W    = 32;
	localparam int REG_IDX_W = 5;

	// ----------------------------------------------------------
	// Data port encodings
	// ----------------------------------------------------------

	// Size of a memory access, NONE is never issued
	typedef enum logic [1:0] {
		BYTE = 2'b00,
		HALF = 2'b01,
		WORD = 2'b10,
		NONE = 2'b11
	} mem_order_t;

	typedef enum logic {
		READ  = 1'b0,
		WRITE = 1'b1
	} mem_rw_t;

	// ----------------------------------------------------------
	// Memory stage state machines
	// ----------------------------------------------------------
	typedef enum logic {
		IDLE = 1'b0,
		WAIT = 1'b1
	} dataio_state_t;

	typedef enum logic {
		PASS      = 1'b0,
		WAIT_DATA = 1'b1
	} next_state_t;

endpackage

`default_nettype wire

// ==== design/mem_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top #(
	parameter int RAM_LATENCY = 3,
	parameter int RAM_WORDS   = 256
) (
	input  wire                                 iCLOCK,
	input  wire                                 inRESET,
	input  wire                                 flush,
	input  wire                                 in_valid,
	input  wire [mem_stage_pkg::DATA_W-1:0]     in_data,
	input  wire [mem_stage_pkg::REG_IDX_W-1:0]  in_dest,
	input  wire                                 in_dest_sysreg,
	input  wire                                 in_writeback,
	input  wire                                 in_mem_valid,
	input  wire [mem_stage_pkg::DATA_W-1:0]     in_mem_addr,
	input  wire [mem_stage_pkg::DATA_W-1:0]     in_mem_wdata,
	input  wire mem_stage_pkg::mem_rw_t         in_mem_rw,
	input  wire mem_stage_pkg::mem_order_t      in_mem_order,
	output logic                                stall,
	input  wire [mem_stage_pkg::REG_IDX_W-1:0]  rd_addr,
	input  wire                                 rd_sysreg,
	output logic [mem_stage_pkg::DATA_W-1:0]    rd_data,
	output logic                                next_valid,
	output logic [mem_stage_pkg::DATA_W-1:0]    next_data,
	output logic [mem_stage_pkg::REG_IDX_W-1:0] next_dest,
	output logic                                next_dest_sysreg,
	output logic                                next_writeback
);
	import mem_stage_pkg::*;

	// Issue register to memory stage
	logic                 prev_valid;
	logic [DATA_W-1:0]    prev_data;
	logic [REG_IDX_W-1:0] prev_dest;
	logic                 prev_dest_sysreg;
	logic                 prev_writeback;
	logic                 prev_mem_valid;
	logic [DATA_W-1:0]    prev_mem_addr;
	logic [DATA_W-1:0]    prev_mem_wdata;
	mem_rw_t              prev_mem_rw;
	mem_order_t           prev_mem_order;
	logic                 lock;

	// Memory stage to data memory
	logic                 req;
	mem_order_t           req_order;
	mem_rw_t              req_rw;
	logic [DATA_W-1:0]    req_addr;
	logic [DATA_W-1:0]    req_wdata;
	logic                 busy;
	logic                 resp;
	logic [DATA_W-1:0]    resp_data;

	assign stall = lock;

	issue_register issue_register_i (.*);

	memory_stage memory_stage_i (.*);

	data_ram #(
		.RAM_LATENCY(RAM_LATENCY),
		.RAM_WORDS  (RAM_WORDS)
	) data_ram_i (.*);

	writeback_regfile writeback_regfile_i (.*);

endmodule

`default_nettype wire

// ==== design/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input  wire                                 iCLOCK,
	input  wire                                 inRESET,
	input  wire                                 flush,
	input  wire                                 prev_valid,
	input  wire [mem_stage_pkg::DATA_W-1:0]     prev_data,
	input  wire [mem_stage_pkg::REG_IDX_W-1:0]  prev_dest,
	input  wire                                 prev_dest_sysreg,
	input  wire                                 prev_writeback,
	input  wire                                 prev_mem_valid,
	input  wire [mem_stage_pkg::DATA_W-1:0]     prev_mem_addr,
	input  wire [mem_stage_pkg::DATA_W-1:0]     prev_mem_wdata,
	input  wire mem_stage_pkg::mem_rw_t         prev_mem_rw,
	input  wire mem_stage_pkg::mem_order_t      prev_mem_order,
	output logic                                lock,
	output logic                                req,
	output mem_stage_pkg::mem_order_t           req_order,
	output mem_stage_pkg::mem_rw_t              req_rw,
	output logic [mem_stage_pkg::DATA_W-1:0]    req_addr,
	output logic [mem_stage_pkg::DATA_W-1:0]    req_wdata,
	input  wire                                 busy,
	input  wire                                 resp,
	input  wire [mem_stage_pkg::DATA_W-1:0]     resp_data,
	output logic                                next_valid,
	output logic [mem_stage_pkg::DATA_W-1:0]    next_data,
	output logic [mem_stage_pkg::REG_IDX_W-1:0] next_dest,
	output logic                                next_dest_sysreg,
	output logic                                next_writeback
);
	import mem_stage_pkg::*;

	dataio_state_t dataio_state;
	next_state_t   next_state;
	logic          start_mem;
	logic          orphan;
	logic          aligned;

	// Nothing moves while the data memory is working on an access
	assign lock      = busy;
	assign start_mem = prev_mem_valid && !lock && (dataio_state == IDLE);

	// ----------------------------------------------------------
	// Request side
	// ----------------------------------------------------------
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			dataio_state <= IDLE;
			req          <= 1'b0;
			orphan       <= 1'b0;
		end else if (flush) begin
			dataio_state <= IDLE;
			req          <= 1'b0;
			// An access already sent is still answered by the memory
			orphan       <= (orphan || dataio_state == WAIT) && !resp;
		end else begin
			req <= 1'b0;
			if (resp)
				orphan <= 1'b0;
			case (dataio_state)
				IDLE: begin
					if (start_mem) begin
						dataio_state <= WAIT;
						req          <= 1'b1;
					end
				end
				WAIT: begin
					if (resp)
						dataio_state <= IDLE;
				end
				default: dataio_state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (start_mem) begin
			req_order <= prev_mem_order;
			req_rw    <= prev_mem_rw;
			req_addr  <= prev_mem_addr;
			req_wdata <= prev_mem_wdata;
		end
	end

	// ----------------------------------------------------------
	// Result side
	// ----------------------------------------------------------
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			next_state <= PASS;
			next_valid <= 1'b0;
		end else if (flush) begin
			next_state <= PASS;
			next_valid <= 1'b0;
		end else begin
			next_valid <= 1'b0;
			case (next_state)
				PASS: begin
					if (!lock) begin
						if (prev_mem_valid)
							next_state <= WAIT_DATA;
						else
							next_valid <= prev_valid;
					end
				end
				WAIT_DATA: begin
					if (resp) begin
						next_state <= PASS;
						next_valid <= 1'b1;
					end
				end
				default: next_state <= PASS;
			endcase
		end
	end

	// Destination fields of a load stay parked here until the response
	always_ff @(posedge iCLOCK) begin
		if (next_state == PASS && !lock) begin
			next_data        <= prev_data;
			next_dest        <= prev_dest;
			next_dest_sysreg <= prev_dest_sysreg;
			next_writeback   <= prev_writeback;
		end else if (next_state == WAIT_DATA && resp) begin
			next_data <= resp_data;
		end
	end

	always_comb begin
		case (prev_mem_order)
			HALF:    aligned = !prev_mem_addr[0];
			WORD:    aligned = (prev_mem_addr[1:0] == 2'b00);
			default: aligned = 1'b1;
		endcase
	end

	assert property (@(posedge iCLOCK) disable iff (!inRESET) req |=> !req)
		else $error("FAIL %0t req expected 0 actual 1", $time);

	// A response with no request outstanding must belong to a flushed access
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(resp && dataio_state == IDLE) |-> orphan)
		else $error("FAIL %0t resp expected 0 actual 1", $time);

	assert property (@(posedge iCLOCK) disable iff (!inRESET) start_mem |-> aligned)
		else $error("FAIL %0t prev_mem_addr expected aligned actual %h",
			$time, prev_mem_addr);

endmodule

`default_nettype wire

// ==== design/writeback_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_regfile (
	input  wire                                iCLOCK,
	input  wire                                inRESET,
	input  wire                                next_valid,
	input  wire [mem_stage_pkg::DATA_W-1:0]    next_data,
	input  wire [mem_stage_pkg::REG_IDX_W-1:0] next_dest,
	input  wire                                next_dest_sysreg,
	input  wire                                next_writeback,
	input  wire [mem_stage_pkg::REG_IDX_W-1:0] rd_addr,
	input  wire                                rd_sysreg,
	output logic [mem_stage_pkg::DATA_W-1:0]   rd_data
);
	import mem_stage_pkg::*;

	localparam int NUM_REGS = 2 ** REG_IDX_W;

	// First index picks the file, 0 for general and 1 for system registers
	logic [DATA_W-1:0] regs [2][NUM_REGS];
	logic              wr_en;

	assign wr_en = next_valid && next_writeback;

	// ----------------------------------------------------------
	// Write port
	// ----------------------------------------------------------
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int f = 0; f < 2; f++) begin
				for (int r = 0; r < NUM_REGS; r++)
					regs[f][r] <= '0;
			end
		end else if (wr_en) begin
			regs[next_dest_sysreg][next_dest] <= next_data;
		end
	end

	// ----------------------------------------------------------
	// Observation read port
	// ----------------------------------------------------------
	assign rd_data = regs[rd_sysreg][rd_addr];

endmodule

`default_nettype wire

// ==== vlog.f ====
design/mem_stage_pkg.sv
design/issue_register.sv
design/memory_stage.sv
design/data_ram.sv
design/writeback_regfile.sv
design/mem_subsystem_top.sv
bench/tb_mem_subsystem.sv
